// ==== rtl/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath width in bits
`define DATA_W 64

// register count with the last one reading as zero
`define REG_COUNT 32

// data memory in doublewords
`define DMEM_DEPTH 64

// index width for address bits 8..3
`define DMEM_AW 6

`endif

// ==== rtl/isaPkg.sv ====
package isaPkg;

    // top 11 bits with '?' as don't-care bits for casez
    typedef enum logic [10:0] {
        opB    = 11'b000101?????,
        opBl   = 11'b100101?????,
        opBlt  = 11'b01010100???,
        opCbz  = 11'b10110100???,
        opBr   = 11'b11010110000,
        opAddi = 11'b10010001000,
        opAdds = 11'b10101011000,
        opSubs = 11'b11101011000,
        opLdur = 11'b11111000010,
        opStur = 11'b11111000000
    } opcodeT;

    localparam int opPos    = 21;  // opcode lsb
    localparam int rdPos    = 0;   // Rd / Rt
    localparam int rnPos    = 5;
    localparam int rmPos    = 16;

    localparam int imm12Pos = 10;  // ADDI
    localparam int imm9Pos  = 12;  // LDUR / STUR
    localparam int imm19Pos = 5;   // CBZ / B.cond
    localparam int imm26Pos = 0;   // B / BL

    localparam int condPos  = 0;   // B.cond condition field

    localparam logic [3:0] condLt = 4'b1011;

    localparam logic [4:0] linkReg = 5'd30;

endpackage

// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

    // ALU function select
    typedef enum logic [2:0] {
        aluPassB = 3'b000,
        aluAdd   = 3'b010,
        aluSub   = 3'b011
    } aluOpT;

    // second ALU operand
    typedef enum logic [1:0] {
        srcReg   = 2'b00,
        srcImm12 = 2'b01,  // zero-extended
        srcImm9  = 2'b10   // sign-extended
    } aluSrcT;

    // register write-back value
    typedef enum logic [1:0] {
        wbAlu  = 2'b00,
        wbMem  = 2'b01,
        wbLink = 2'b10     // pc + 4
    } wbSrcT;

    // next pc choice made in the decoder
    typedef enum logic [1:0] {
        pcSeq = 2'b00,
        pcRel = 2'b01,
        pcReg = 2'b10
    } nextPcT;

endpackage

// ==== rtl/ctrlIf.sv ====
`timescale 1ns/100ps

interface ctrlIf;

    ctrlPkg::aluOpT  aluOp;
    ctrlPkg::aluSrcT aluSrc;
    ctrlPkg::wbSrcT  wbSrc;
    ctrlPkg::nextPcT nextPc;
    logic            uncondBr;   // imm26 rather than imm19
    logic            reg2Loc;    // port B reads Rm
    logic            regWrite;
    logic            linkWrite;  // write to x30
    logic            memWrite;
    logic            setFlags;

    modport decoder (
        output aluOp, aluSrc, wbSrc, nextPc, uncondBr,
        output reg2Loc, regWrite, linkWrite, memWrite, setFlags
    );

    modport datapath (
        input aluOp, aluSrc, wbSrc, nextPc, uncondBr,
        input reg2Loc, regWrite, linkWrite, memWrite, setFlags
    );

endinterface

// ==== rtl/controlDecode.sv ====
`timescale 1ns/100ps

module controlDecode (
    input  logic [31:0] instruction,
    input  logic        flagN,
    input  logic        flagV,
    input  logic        aluZero,
    ctrlIf.decoder      ctl
);

    logic [10:0] opcode;
    logic        ltTaken;

    assign opcode  = instruction[isaPkg::opPos +: 11];
    assign ltTaken = (instruction[isaPkg::condPos +: 4] == isaPkg::condLt) &&
                     (flagN != flagV);

    // unknown opcodes stay a no-op
    always_comb begin
        ctl.aluOp     = ctrlPkg::aluPassB;
        ctl.aluSrc    = ctrlPkg::srcReg;
        ctl.wbSrc     = ctrlPkg::wbAlu;
        ctl.uncondBr  = 1'b0;
        ctl.reg2Loc   = 1'b0;
        ctl.regWrite  = 1'b0;
        ctl.linkWrite = 1'b0;
        ctl.memWrite  = 1'b0;
        ctl.setFlags  = 1'b0;
        casez (opcode)
            isaPkg::opB: begin
                ctl.uncondBr = 1'b1;
            end
            isaPkg::opBl: begin
                ctl.uncondBr  = 1'b1;
                ctl.regWrite  = 1'b1;
                ctl.linkWrite = 1'b1;
                ctl.wbSrc     = ctrlPkg::wbLink;
            end
            isaPkg::opCbz: begin
                ctl.aluOp = ctrlPkg::aluPassB;  // Rt through the ALU for zero
            end
            isaPkg::opAddi: begin
                ctl.aluOp    = ctrlPkg::aluAdd;
                ctl.aluSrc   = ctrlPkg::srcImm12;
                ctl.regWrite = 1'b1;
            end
            isaPkg::opAdds, isaPkg::opSubs: begin
                ctl.aluOp    = (opcode == isaPkg::opSubs) ? ctrlPkg::aluSub
                                                          : ctrlPkg::aluAdd;
                ctl.reg2Loc  = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.setFlags = 1'b1;
            end
            isaPkg::opLdur: begin
                ctl.aluOp    = ctrlPkg::aluAdd;
                ctl.aluSrc   = ctrlPkg::srcImm9;
                ctl.wbSrc    = ctrlPkg::wbMem;
                ctl.regWrite = 1'b1;
            end
            isaPkg::opStur: begin
                ctl.aluOp    = ctrlPkg::aluAdd;
                ctl.aluSrc   = ctrlPkg::srcImm9;
                ctl.memWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // branch resolution from flags and ALU zero
    always_comb begin
        ctl.nextPc = ctrlPkg::pcSeq;
        casez (opcode)
            isaPkg::opB, isaPkg::opBl: ctl.nextPc = ctrlPkg::pcRel;
            isaPkg::opCbz: begin
                if (aluZero) begin
                    ctl.nextPc = ctrlPkg::pcRel;
                end
            end
            isaPkg::opBlt: begin
                if (ltTaken) begin
                    ctl.nextPc = ctrlPkg::pcRel;
                end
            end
            isaPkg::opBr: ctl.nextPc = ctrlPkg::pcReg;
            default: begin
            end
        endcase
    end

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  logic [4:0]         rdAddrA,
    input  logic [4:0]         rdAddrB,
    input  logic [4:0]         wrAddr,
    input  logic               wrEn,
    input  logic [`DATA_W-1:0] wrData,
    output logic [`DATA_W-1:0] rdDataA,
    output logic [`DATA_W-1:0] rdDataB
);

    localparam logic [4:0] zeroReg = 5'(`REG_COUNT - 1);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != zeroReg)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // xzr reads zero
    assign rdDataA = (rdAddrA == zeroReg) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == zeroReg) ? '0 : regs[rdAddrB];

endmodule

// ==== rtl/aluFlags.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"

module aluFlags (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`DATA_W-1:0] opA,
    input  logic [`DATA_W-1:0] opB,
    input  ctrlPkg::aluOpT     aluOp,
    input  logic               setFlags,
    output logic [`DATA_W-1:0] result,
    output logic               zero,
    output logic               flagN,
    output logic               flagV
);

    localparam int msb = `DATA_W - 1;

    logic [`DATA_W:0] sum;       // carry in the top bit
    logic             carry;
    logic             overflow;
    logic [3:0]       nzcv;

    always_comb begin
        sum      = '0;
        overflow = 1'b0;
        case (aluOp)
            ctrlPkg::aluAdd: begin
                sum      = {1'b0, opA} + {1'b0, opB};
                overflow = (opA[msb] == opB[msb]) && (sum[msb] != opA[msb]);
            end
            ctrlPkg::aluSub: begin
                sum      = {1'b0, opA} + {1'b0, ~opB} + (`DATA_W+1)'(1);  // carry = no borrow
                overflow = (opA[msb] != opB[msb]) && (sum[msb] != opA[msb]);
            end
            default: begin
                sum = {1'b0, opB};
            end
        endcase
    end

    assign result = sum[msb:0];
    assign carry  = sum[`DATA_W];
    assign zero   = (result == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            nzcv <= 4'b0000;
        end else if (setFlags) begin
            nzcv <= {result[msb], zero, carry, overflow};
        end
    end

    assign flagN = nzcv[3];
    assign flagV = nzcv[0];

endmodule

// ==== rtl/dataMem.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"

module dataMem (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`DATA_W-1:0] addr,
    input  logic               wrEn,
    input  logic [`DATA_W-1:0] wrData,
    output logic [`DATA_W-1:0] rdData
);

    logic [`DATA_W-1:0]  mem [`DMEM_DEPTH];
    logic [`DMEM_AW-1:0] index;

    assign index  = addr[`DMEM_AW+2:3];  // doubleword index
    assign rdData = mem[index];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            mem[index] <= wrData;
        end
    end

endmodule

// ==== rtl/cpuCore.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpuCore (
    input  logic               clk,
    input  logic               rstN,
    output logic [`DATA_W-1:0] pc,
    input  logic [31:0]        instruction,
    output logic               regWrEn,
    output logic [4:0]         regWrAddr,
    output logic [`DATA_W-1:0] regWrData,
    output logic               memWrEn,
    output logic [`DATA_W-1:0] memWrAddr,
    output logic [`DATA_W-1:0] memWrData
);

    localparam logic [4:0] zeroReg = 5'(`REG_COUNT - 1);

    ctrlIf ctl ();

    logic [4:0]         rdAddrB;
    logic [`DATA_W-1:0] rdDataA;
    logic [`DATA_W-1:0] rdDataB;
    logic [`DATA_W-1:0] aluOperandB;
    logic [`DATA_W-1:0] aluResult;
    logic               aluZero;
    logic               flagN;
    logic               flagV;
    logic [`DATA_W-1:0] memRdData;
    logic [`DATA_W-1:0] imm12Ext;
    logic [`DATA_W-1:0] imm9Ext;
    logic [`DATA_W-1:0] imm19Ext;
    logic [`DATA_W-1:0] imm26Ext;
    logic [`DATA_W-1:0] branchOffset;
    logic [`DATA_W-1:0] pcPlus4;
    logic [`DATA_W-1:0] pcNext;

    controlDecode decoder (
        .instruction(instruction),
        .flagN      (flagN),
        .flagV      (flagV),
        .aluZero    (aluZero),
        .ctl        (ctl)
    );

    // Rt doubles as store data and the CBZ / BR operand
    assign rdAddrB = ctl.reg2Loc ? instruction[isaPkg::rmPos +: 5]
                                 : instruction[isaPkg::rdPos +: 5];

    regFile regs (
        .clk    (clk),
        .rstN   (rstN),
        .rdAddrA(instruction[isaPkg::rnPos +: 5]),
        .rdAddrB(rdAddrB),
        .wrAddr (regWrAddr),
        .wrEn   (regWrEn),
        .wrData (regWrData),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB)
    );

    assign imm12Ext = {{(`DATA_W-12){1'b0}}, instruction[isaPkg::imm12Pos +: 12]};
    assign imm9Ext  = {{(`DATA_W-9){instruction[isaPkg::imm9Pos+8]}},
                       instruction[isaPkg::imm9Pos +: 9]};
    assign imm19Ext = {{(`DATA_W-19){instruction[isaPkg::imm19Pos+18]}},
                       instruction[isaPkg::imm19Pos +: 19]};
    assign imm26Ext = {{(`DATA_W-26){instruction[isaPkg::imm26Pos+25]}},
                       instruction[isaPkg::imm26Pos +: 26]};

    always_comb begin
        case (ctl.aluSrc)
            ctrlPkg::srcImm12: aluOperandB = imm12Ext;
            ctrlPkg::srcImm9:  aluOperandB = imm9Ext;
            default:           aluOperandB = rdDataB;
        endcase
    end

    aluFlags alu (
        .clk     (clk),
        .rstN    (rstN),
        .opA     (rdDataA),
        .opB     (aluOperandB),
        .aluOp   (ctl.aluOp),
        .setFlags(ctl.setFlags),
        .result  (aluResult),
        .zero    (aluZero),
        .flagN   (flagN),
        .flagV   (flagV)
    );

    dataMem dmem (
        .clk   (clk),
        .rstN  (rstN),
        .addr  (aluResult),
        .wrEn  (memWrEn),
        .wrData(rdDataB),
        .rdData(memRdData)
    );

    assign pcPlus4 = pc + `DATA_W'(4);

    // xzr writes dropped at write-back too
    assign regWrAddr = ctl.linkWrite ? isaPkg::linkReg : instruction[isaPkg::rdPos +: 5];
    assign regWrEn   = rstN && ctl.regWrite && (regWrAddr != zeroReg);

    always_comb begin
        case (ctl.wbSrc)
            ctrlPkg::wbMem:  regWrData = memRdData;
            ctrlPkg::wbLink: regWrData = pcPlus4;
            default:         regWrData = aluResult;
        endcase
    end

    assign memWrEn   = rstN && ctl.memWrite;
    assign memWrAddr = aluResult;
    assign memWrData = rdDataB;

    assign branchOffset = (ctl.uncondBr ? imm26Ext : imm19Ext) << 2;  // word offset

    always_comb begin
        case (ctl.nextPc)
            ctrlPkg::pcRel: pcNext = pc + branchOffset;
            ctrlPkg::pcReg: pcNext = rdDataB;
            default:        pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/100ps

module clockGen #(
    parameter int periodNs    = 20,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic rstN
);

    initial clk = 1'b0;
    always #(periodNs / 2) clk = ~clk;

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);  // release away from the active edge
        rstN = 1'b1;
    end

endmodule

// ==== dv/cpuCore_assertions.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpuCore_assertions (
    input logic               clk,
    input logic               rstN,
    input logic [`DATA_W-1:0] pc,
    input logic               regWrEn,
    input logic [4:0]         regWrAddr,
    input logic               memWrEn
);

    // nothing commits while reset is held
    quietInReset: assert property (@(posedge clk) !rstN |-> (!regWrEn && !memWrEn))
        else $error("write enable high during reset");

    noZeroRegWrite: assert property (
        @(posedge clk) disable iff (!rstN) regWrEn |-> (regWrAddr != 5'd31)
    ) else $error("register write aimed at xzr");

    pcAligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

// ==== dv/cpuCore_tb.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpuCore_tb;

    localparam int progLen   = 200;
    localparam int haltLoops = 5;
    localparam int timeoutNs = (8 + progLen + 20) * 20 + 1000;
    localparam logic [31:0] haltWord = {6'b000101, 26'd0};  // B .

    logic               clk;
    logic               rstN;
    logic [`DATA_W-1:0] pc;
    logic [31:0]        instruction;
    logic               regWrEn;
    logic [4:0]         regWrAddr;
    logic [`DATA_W-1:0] regWrData;
    logic               memWrEn;
    logic [`DATA_W-1:0] memWrAddr;
    logic [`DATA_W-1:0] memWrData;

    logic [31:0] prog [progLen];
    int          branchTgt [progLen];
    logic [31:0] lcgState = 32'd58;

    // reference model state
    logic [`DATA_W-1:0] mReg [`REG_COUNT];
    logic [`DATA_W-1:0] mMem [`DMEM_DEPTH];
    logic               mN;
    logic               mV;
    logic [`DATA_W-1:0] mPc;
    logic               expRegEn;
    logic [4:0]         expRegAddr;
    logic [`DATA_W-1:0] expRegData;
    logic               expMemEn;
    logic [`DATA_W-1:0] expMemAddr;
    logic [`DATA_W-1:0] expMemData;

    int checkCount = 0;
    int pcErrors   = 0;
    int regErrors  = 0;
    int memErrors  = 0;

    clockGen clocks (.clk(clk), .rstN(rstN));

    cpuCore uut (
        .clk        (clk),
        .rstN       (rstN),
        .pc         (pc),
        .instruction(instruction),
        .regWrEn    (regWrEn),
        .regWrAddr  (regWrAddr),
        .regWrData  (regWrData),
        .memWrEn    (memWrEn),
        .memWrAddr  (memWrAddr),
        .memWrData  (memWrData)
    );

    bind cpuCore cpuCore_assertions asserts (
        .clk(clk), .rstN(rstN), .pc(pc),
        .regWrEn(regWrEn), .regWrAddr(regWrAddr), .memWrEn(memWrEn)
    );

    function automatic int nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[30:16]);
    endfunction

    function automatic int randBelow(int n);
        return nextRand() % n;
    endfunction

    function automatic logic [4:0] pickReg();
        if (randBelow(10) == 0) begin
            return 5'd31;  // xzr now and then
        end
        return 5'(randBelow(8));
    endfunction

    function automatic logic [31:0] encR(logic [10:0] opc, logic [4:0] rd, logic [4:0] rn,
                                         logic [4:0] rm);
        return {opc, rm, 6'd0, rn, rd};
    endfunction

    function automatic logic [31:0] encAddi(logic [4:0] rd, logic [4:0] rn, logic [11:0] imm);
        return {10'b1001000100, imm, rn, rd};
    endfunction

    function automatic logic [31:0] encD(logic [10:0] opc, logic [4:0] rt, logic [8:0] imm);
        return {opc, imm, 2'b00, 5'd31, rt};  // base is xzr
    endfunction

    function automatic logic [31:0] encCb(logic [7:0] opc, logic [4:0] rt, int off);
        return {opc, 19'(off), rt};
    endfunction

    // true when a branch already placed targets word t
    function automatic logic landsOn(int t);
        for (int j = t - 4; j < t; j++) begin
            if (j >= 0 && branchTgt[j] == t) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic buildProgram();
        int i;
        int r;
        int off;
        logic [4:0] rt;
        for (int k = 0; k < progLen; k++) begin
            branchTgt[k] = -1;
        end
        i = 0;
        while (i < progLen) begin
            r   = randBelow(100);
            off = 1 + randBelow(4);
            rt  = 5'(randBelow(8));
            if (r < 2) begin
                prog[i] = (randBelow(2) == 0) ? 32'h0000_0000 : 32'hD503_201F;
            end else if (r < 22) begin
                prog[i] = encAddi(pickReg(), pickReg(), 12'(randBelow(2048)));
            end else if (r < 42) begin
                prog[i] = encR(11'b10101011000, pickReg(), pickReg(), pickReg());
            end else if (r < 62) begin
                prog[i] = encR(11'b11101011000, pickReg(), pickReg(), pickReg());
            end else if (r < 72) begin
                prog[i] = encD(11'b11111000010, pickReg(), 9'(8 * randBelow(8)));
            end else if (r < 82) begin
                prog[i] = encD(11'b11111000000, pickReg(), 9'(8 * randBelow(8)));
            end else if (r < 89) begin
                prog[i] = {(r < 86) ? 6'b000101 : 6'b100101, 26'(off)};  // B or BL
                branchTgt[i] = i + off;
            end else if (r < 93) begin
                prog[i] = encCb(8'b10110100, pickReg(), off);
                branchTgt[i] = i + off;
            end else if (r < 97) begin
                prog[i] = encCb(8'b01010100, 5'b01011, off);  // B.LT
                branchTgt[i] = i + off;
            end else if (i + 1 < progLen && !landsOn(i + 1)) begin
                // a jump onto the BR alone would see a stale target
                prog[i]     = encAddi(rt, 5'd31, 12'((i + 1 + off) * 4));
                prog[i + 1] = {11'b11010110000, 5'b11111, 6'd0, 5'd0, rt};
                branchTgt[i + 1] = i + 1 + off;
                i++;
            end else begin
                prog[i] = encAddi(pickReg(), pickReg(), 12'(randBelow(2048)));
            end
            i++;
        end
    endtask

    function automatic logic [31:0] fetchWord(logic [`DATA_W-1:0] addr);
        if (addr[1:0] != 2'b00 || addr >= `DATA_W'(progLen * 4)) begin
            return haltWord;
        end
        return prog[addr[9:2]];
    endfunction

    function automatic logic [`DATA_W-1:0] readReg(logic [4:0] r);
        return (r == 5'd31) ? '0 : mReg[r];
    endfunction

    // steps the ISA model and sets the expected trace
    task automatic modelStep(input logic [31:0] w);
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] addr;
        logic [`DATA_W-1:0] nextPc;
        logic signed [`DATA_W:0] wide;
        a          = readReg(w[9:5]);
        b          = readReg(w[20:16]);
        addr       = a + {{55{w[20]}}, w[20:12]};
        nextPc     = mPc + 64'd4;
        expRegEn   = 1'b0;
        expRegAddr = w[4:0];
        expRegData = '0;
        expMemEn   = 1'b0;
        expMemAddr = '0;
        expMemData = '0;
        casez (w[31:21])
            11'b000101?????: nextPc = mPc + {{36{w[25]}}, w[25:0], 2'b00};
            11'b100101?????: begin
                nextPc     = mPc + {{36{w[25]}}, w[25:0], 2'b00};
                expRegEn   = 1'b1;
                expRegAddr = 5'd30;
                expRegData = mPc + 64'd4;
            end
            11'b10110100???: begin
                if (readReg(w[4:0]) == '0) nextPc = mPc + {{43{w[23]}}, w[23:5], 2'b00};
            end
            11'b01010100???: begin
                if (w[3:0] == 4'b1011 && mN != mV) begin
                    nextPc = mPc + {{43{w[23]}}, w[23:5], 2'b00};
                end
            end
            11'b11010110000: nextPc = readReg(w[4:0]);
            11'b10010001000: begin
                expRegEn   = 1'b1;
                expRegData = a + {52'd0, w[21:10]};
            end
            11'b10101011000, 11'b11101011000: begin
                if (w[30]) wide = $signed({a[63], a}) - $signed({b[63], b});
                else       wide = $signed({a[63], a}) + $signed({b[63], b});
                expRegEn   = 1'b1;
                expRegData = wide[`DATA_W-1:0];
                mN         = wide[63];
                mV         = wide[64] ^ wide[63];  // result does not fit in 64 bits
            end
            11'b11111000010: begin
                expRegEn   = 1'b1;
                expRegData = mMem[addr[8:3]];
            end
            11'b11111000000: begin
                expMemEn   = 1'b1;
                expMemAddr = addr;
                expMemData = readReg(w[4:0]);
                mMem[addr[8:3]] = expMemData;
            end
            default: begin
            end
        endcase
        if (expRegAddr == 5'd31) expRegEn = 1'b0;
        if (expRegEn) mReg[expRegAddr] = expRegData;
        mPc = nextPc;
    endtask

    task automatic checkPc(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] want);
        checkCount++;
        if (got !== want) begin
            $display("CHECK FAILED at %0t: pc got %h expected %h", $time, got, want);
            pcErrors++;
        end
    endtask

    task automatic checkRegWrite(input logic gotEn, input logic [4:0] gotAddr,
                                 input logic [`DATA_W-1:0] gotData, input logic wantEn,
                                 input logic [4:0] wantAddr, input logic [`DATA_W-1:0] wantData);
        checkCount++;
        if (gotEn !== wantEn) begin
            $display("CHECK FAILED at %0t: regWrEn got %b expected %b", $time, gotEn, wantEn);
            regErrors++;
        end else if (wantEn && gotAddr !== wantAddr) begin
            $display("CHECK FAILED at %0t: regWrAddr got %0d expected %0d", $time, gotAddr,
                     wantAddr);
            regErrors++;
        end else if (wantEn && gotData !== wantData) begin
            $display("CHECK FAILED at %0t: regWrData got %h expected %h", $time, gotData,
                     wantData);
            regErrors++;
        end
    endtask

    task automatic checkMemWrite(input logic gotEn, input logic [`DATA_W-1:0] gotAddr,
                                 input logic [`DATA_W-1:0] gotData, input logic wantEn,
                                 input logic [`DATA_W-1:0] wantAddr,
                                 input logic [`DATA_W-1:0] wantData);
        checkCount++;
        if (gotEn !== wantEn) begin
            $display("CHECK FAILED at %0t: memWrEn got %b expected %b", $time, gotEn, wantEn);
            memErrors++;
        end else if (wantEn && gotAddr !== wantAddr) begin
            $display("CHECK FAILED at %0t: memWrAddr got %h expected %h", $time, gotAddr,
                     wantAddr);
            memErrors++;
        end else if (wantEn && gotData !== wantData) begin
            $display("CHECK FAILED at %0t: memWrData got %h expected %h", $time, gotData,
                     wantData);
            memErrors++;
        end
    endtask

    initial begin
        int haltCycles;
        logic [31:0] word;
        haltCycles  = 0;
        instruction = '0;
        mPc = '0;
        mN  = 1'b0;
        mV  = 1'b0;
        for (int k = 0; k < `REG_COUNT; k++) mReg[k] = '0;
        for (int k = 0; k < `DMEM_DEPTH; k++) mMem[k] = '0;
        buildProgram();
        while (haltCycles < haltLoops) begin
            @(negedge clk);
            instruction = fetchWord(pc);
            #1;  // let the combinational trace settle
            if (!rstN) begin
                checkPc(pc, '0);
                checkRegWrite(regWrEn, regWrAddr, regWrData, 1'b0, '0, '0);
                checkMemWrite(memWrEn, memWrAddr, memWrData, 1'b0, '0, '0);
            end else begin
                checkPc(pc, mPc);
                word = fetchWord(mPc);
                if (word == haltWord) haltCycles++;
                modelStep(word);
                checkRegWrite(regWrEn, regWrAddr, regWrData, expRegEn, expRegAddr, expRegData);
                checkMemWrite(memWrEn, memWrAddr, memWrData, expMemEn, expMemAddr, expMemData);
            end
        end
        $display("checks %0d, pc errors %0d, register write errors %0d, store errors %0d",
                 checkCount, pcErrors, regErrors, memErrors);
        if (pcErrors + regErrors + memErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeoutNs);
        $display("timeout: the program never settled in its halt loop");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/ctrlIf.sv
rtl/controlDecode.sv
rtl/regFile.sv
rtl/aluFlags.sv
rtl/dataMem.sv
rtl/cpuCore.sv
dv/clockGen.sv
dv/cpuCore_assertions.sv
dv/cpuCore_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpuCore_tb
FILELIST = list.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
